//--- rtl/icache_settings.svh
////////////////////////////////////////////////////////////////////////////
// instruction cache geometry and widths
// seed of the replacement shift register
////////////////////////////////////////////////////////////////////////////

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// physical byte address width
`define ICACHE_ADDR_WIDTH 32

// associativity and number of sets
`define ICACHE_NUM_WAYS 4
`define ICACHE_NUM_SETS 16

// line size in bytes, one refill beat carries a full line
`define ICACHE_LINE_BYTES 16

// bits per fetch word
`define ICACHE_FETCH_WIDTH 32

// reset value of the 8-bit replacement shift register, must be nonzero
`define ICACHE_LFSR_SEED 8'h5a

`endif

//--- rtl/icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache package
// derived widths, address union, refill request and row types
////////////////////////////////////////////////////////////////////////////

`include "icache_settings.svh"

package icache_pkg;

  // derived widths
  localparam int ADDR_WIDTH   = `ICACHE_ADDR_WIDTH;
  localparam int OFFSET_WIDTH = $clog2(`ICACHE_LINE_BYTES);
  localparam int INDEX_WIDTH  = $clog2(`ICACHE_NUM_SETS);
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WAY_WIDTH    = $clog2(`ICACHE_NUM_WAYS);
  localparam int LINE_WIDTH   = `ICACHE_LINE_BYTES * 8;

  // byte address split as the cache sees it
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
  } addr_fields_t;

  // same address word, raw or decoded into fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    addr_fields_t          fields;
  } icache_addr_u;

  // refill request, line aligned address plus the way to be replaced
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [WAY_WIDTH-1:0]  way;
  } mem_req_t;

  // one tag per way of a set
  typedef logic [`ICACHE_NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rows_t;

  // one line per way of a set
  typedef logic [`ICACHE_NUM_WAYS-1:0][LINE_WIDTH-1:0] line_rows_t;

  // fetch response word and the address it belongs to
  typedef struct packed {
    logic [`ICACHE_FETCH_WIDTH-1:0] data;
    logic [ADDR_WIDTH-1:0]          addr;
  } fetch_rsp_t;

endpackage

//--- rtl/icache_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache controller
// flush, idle, compare and miss FSM, request registers, miss pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  // fetch port
  input  logic                               fetch_req_i,
  input  icache_pkg::icache_addr_u           fetch_addr_i,
  output logic                               fetch_ready_o,
  output logic                               fetch_valid_o,
  input  logic                               hit_i,
  // refill port
  output logic                               mem_req_o,
  output icache_pkg::mem_req_t               mem_req_data_o,
  input  logic                               mem_ack_i,
  input  logic                               mem_rtrn_vld_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]   victim_way_i,
  // array control
  output logic                               lookup_o,
  output logic                               refill_o,
  output logic                               sweep_o,
  input  logic                               sweep_done_i,
  output logic [icache_pkg::INDEX_WIDTH-1:0] index_o,
  output icache_pkg::icache_addr_u           req_addr_o,
  output logic                               cmp_en_o,
  // performance counter
  output logic                               miss_o
);

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    COMPARE,
    MISS
  } state_e;

  state_e state_d, state_q;
  icache_pkg::icache_addr_u addr_q;
  icache_pkg::icache_addr_u line_addr;
  logic flush_d, flush_q;
  logic cmp_en_d, cmp_en_q;
  logic miss_d;

  ////////////////////////////////////////////////////////////////////////////
  // request plumbing
  ////////////////////////////////////////////////////////////////////////////

  // a new lookup indexes with the incoming address, refills use the held one
  assign index_o    = lookup_o ? fetch_addr_i.fields.index : addr_q.fields.index;
  assign req_addr_o = addr_q;
  assign cmp_en_o   = cmp_en_q;
  assign sweep_o    = (state_q == FLUSH);

  // refill address is the held address with the offset cleared
  always_comb begin
    line_addr               = addr_q;
    line_addr.fields.offset = '0;
    mem_req_data_o.addr     = line_addr.raw;
    mem_req_data_o.way      = victim_way_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    // hold an incoming flush until the sweep runs
    flush_d       = flush_q | flush_i;
    cmp_en_d      = 1'b0;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    lookup_o      = 1'b0;
    refill_o      = 1'b0;
    mem_req_o     = 1'b0;
    miss_d        = 1'b0;

    unique case (state_q)
      // clear one set per cycle, the tag store counts
      FLUSH: begin
        if (sweep_done_i) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      // wait for a fetch, a pending flush goes first
      IDLE: begin
        if (flush_d) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            lookup_o = 1'b1;
            cmp_en_d = 1'b1;
            state_d  = COMPARE;
          end
        end
      end
      // tags and lines are out of the arrays now
      COMPARE: begin
        if (hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // stream the next fetch unless a flush waits
          if (!flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              lookup_o = 1'b1;
              cmp_en_d = 1'b1;
              state_d  = COMPARE;
            end
          end
        end else begin
          // miss, hold the refill request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_d  = 1'b1;
            state_d = MISS;
          end
        end
      end
      // the returning line is consumed in its only beat
      MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          refill_o      = 1'b1;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= FLUSH;
      flush_q  <= 1'b0;
      cmp_en_q <= 1'b0;
      miss_o   <= 1'b0;
    end else begin
      state_q  <= state_d;
      flush_q  <= flush_d;
      cmp_en_q <= cmp_en_d;
      miss_o   <= miss_d;
    end
  end

  // accepted fetch address
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      addr_q <= fetch_addr_i;
    end
  end

endmodule

//--- rtl/icache_tag_store.sv
////////////////////////////////////////////////////////////////////////////
// tag and valid arrays with registered read
// flush sweep counter and victim way choice
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tag_store (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               lookup_i,
  input  logic                               refill_i,
  input  logic                               sweep_i,
  input  logic [icache_pkg::INDEX_WIDTH-1:0] index_i,
  input  icache_pkg::icache_addr_u           req_addr_i,
  input  logic                               cmp_en_i,
  output icache_pkg::tag_rows_t              tag_rows_o,
  output logic [`ICACHE_NUM_WAYS-1:0]        valid_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]   victim_way_o,
  output logic                               sweep_done_o
);

  icache_pkg::tag_rows_t tag_mem [`ICACHE_NUM_SETS];
  logic [`ICACHE_NUM_WAYS-1:0] valid_mem [`ICACHE_NUM_SETS];
  icache_pkg::tag_rows_t tag_rows_q;
  logic [`ICACHE_NUM_WAYS-1:0] valid_q;
  logic [icache_pkg::INDEX_WIDTH-1:0] sweep_cnt_q;
  logic [7:0] lfsr_q;
  logic lfsr_fb;
  logic [icache_pkg::WAY_WIDTH-1:0] inv_way;
  logic [icache_pkg::WAY_WIDTH-1:0] repl_way;
  logic [icache_pkg::WAY_WIDTH-1:0] victim_q;
  logic all_valid;
  logic full_q;

  ////////////////////////////////////////////////////////////////////////////
  // arrays
  ////////////////////////////////////////////////////////////////////////////

  // sweep clears a whole set, refill sets one way of the held index
  always_ff @(posedge clk_i) begin
    if (sweep_i) begin
      valid_mem[sweep_cnt_q] <= '0;
    end else if (refill_i) begin
      valid_mem[index_i][victim_q] <= 1'b1;
      tag_mem[index_i][victim_q]   <= req_addr_i.fields.tag;
    end
  end

  // registered read of all ways
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (lookup_i) begin
      valid_q <= valid_mem[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      tag_rows_q <= tag_mem[index_i];
    end
  end

  assign tag_rows_o = tag_rows_q;
  assign valid_o    = valid_q;

  // sweep counter wraps to zero after the last set
  assign sweep_done_o = sweep_i && (sweep_cnt_q == icache_pkg::INDEX_WIDTH'(`ICACHE_NUM_SETS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////////////////////

  // lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w]) begin
        inv_way = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  assign all_valid = &valid_q;
  assign repl_way  = all_valid ? lfsr_q[icache_pkg::WAY_WIDTH-1:0] : inv_way;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // victim is live during compare, held afterwards for request and refill
  assign victim_way_o = cmp_en_i ? repl_way : victim_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sweep_cnt_q <= '0;
      lfsr_q      <= `ICACHE_LFSR_SEED;
      victim_q    <= '0;
      full_q      <= 1'b0;
    end else begin
      if (sweep_i) begin
        sweep_cnt_q <= sweep_cnt_q + 1'b1;
      end
      if (cmp_en_i) begin
        victim_q <= repl_way;
        full_q   <= all_valid;
      end
      // only a refill into a full set consumes a random way
      if (refill_i && full_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

endmodule

//--- rtl/icache_line_store.sv
////////////////////////////////////////////////////////////////////////////
// line data arrays, one per way
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_line_store (
  input  logic                               clk_i,
  input  logic                               lookup_i,
  input  logic                               refill_i,
  input  logic [icache_pkg::INDEX_WIDTH-1:0] index_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]   victim_way_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0]  mem_rtrn_line_i,
  output icache_pkg::line_rows_t             lines_o
);

  icache_pkg::line_rows_t data_mem [`ICACHE_NUM_SETS];
  icache_pkg::line_rows_t lines_q;

  // refill writes the whole line into the victim way
  always_ff @(posedge clk_i) begin
    if (refill_i) begin
      data_mem[index_i][victim_way_i] <= mem_rtrn_line_i;
    end
  end

  // lookup reads every way of the set
  // the result is ready in the compare cycle
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      lines_q <= data_mem[index_i];
    end
  end

  assign lines_o = lines_q;

endmodule

//--- rtl/icache_way_select.sv
////////////////////////////////////////////////////////////////////////////
// tag compare, hit detection and fetch word select
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way_select (
  input  logic                              cmp_en_i,
  input  icache_pkg::icache_addr_u          req_addr_i,
  input  icache_pkg::tag_rows_t             tag_rows_i,
  input  logic [`ICACHE_NUM_WAYS-1:0]       valid_i,
  input  icache_pkg::line_rows_t            lines_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0] mem_rtrn_line_i,
  output logic                              hit_o,
  output icache_pkg::fetch_rsp_t            rsp_o
);

  // word index inside a line, byte bits below the word are ignored
  localparam int WORD_SEL_WIDTH = icache_pkg::OFFSET_WIDTH - $clog2(`ICACHE_FETCH_WIDTH / 8);

  logic [`ICACHE_NUM_WAYS-1:0] hit_vec;
  logic [icache_pkg::WAY_WIDTH-1:0] hit_way;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic [icache_pkg::LINE_WIDTH-1:0] src_line;

  // per way compare, qualified by valid and by the compare cycle
  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = cmp_en_i & valid_i[w] & (tag_rows_i[w] == req_addr_i.fields.tag);
      if (hit_vec[w]) begin
        hit_way = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  assign hit_o = |hit_vec;

  // hit way while comparing, else the line coming back from memory
  assign src_line = cmp_en_i ? lines_i[hit_way] : mem_rtrn_line_i;
  assign word_sel = req_addr_i.fields.offset[icache_pkg::OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];

  assign rsp_o.data = src_line[word_sel * `ICACHE_FETCH_WIDTH +: `ICACHE_FETCH_WIDTH];
  assign rsp_o.addr = req_addr_i.raw;

endmodule

//--- rtl/icache_top.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache top level
// controller, tag store, line store and way selector
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // fetch port
  input  logic                              fetch_req_i,
  input  icache_pkg::icache_addr_u          fetch_addr_i,
  output logic                              fetch_ready_o,
  output logic                              fetch_valid_o,
  output icache_pkg::fetch_rsp_t            fetch_rsp_o,
  // refill port
  output logic                              mem_req_o,
  output icache_pkg::mem_req_t              mem_req_data_o,
  input  logic                              mem_ack_i,
  input  logic                              mem_rtrn_vld_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0] mem_rtrn_line_i,
  // performance counter
  output logic                              miss_o
);

  // controller to stores
  logic lookup;
  logic refill;
  logic sweep;
  logic sweep_done;
  logic cmp_en;
  logic [icache_pkg::INDEX_WIDTH-1:0] index;
  icache_pkg::icache_addr_u req_addr;

  // store results
  icache_pkg::tag_rows_t tag_rows;
  logic [`ICACHE_NUM_WAYS-1:0] valid;
  logic [icache_pkg::WAY_WIDTH-1:0] victim_way;
  icache_pkg::line_rows_t lines;
  logic hit;

  icache_ctrl icache_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_valid_o  (fetch_valid_o),
    .hit_i          (hit),
    .mem_req_o      (mem_req_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .victim_way_i   (victim_way),
    .lookup_o       (lookup),
    .refill_o       (refill),
    .sweep_o        (sweep),
    .sweep_done_i   (sweep_done),
    .index_o        (index),
    .req_addr_o     (req_addr),
    .cmp_en_o       (cmp_en),
    .miss_o         (miss_o)
  );

  icache_tag_store icache_tag_store_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_i     (lookup),
    .refill_i     (refill),
    .sweep_i      (sweep),
    .index_i      (index),
    .req_addr_i   (req_addr),
    .cmp_en_i     (cmp_en),
    .tag_rows_o   (tag_rows),
    .valid_o      (valid),
    .victim_way_o (victim_way),
    .sweep_done_o (sweep_done)
  );

  icache_line_store icache_line_store_i (
    .clk_i           (clk_i),
    .lookup_i        (lookup),
    .refill_i        (refill),
    .index_i         (index),
    .victim_way_i    (victim_way),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .lines_o         (lines)
  );

  icache_way_select icache_way_select_i (
    .cmp_en_i        (cmp_en),
    .req_addr_i      (req_addr),
    .tag_rows_i      (tag_rows),
    .valid_i         (valid),
    .lines_i         (lines),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .hit_o           (hit),
    .rsp_o           (fetch_rsp_o)
  );

endmodule

//--- verif/icache_assert.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the refill request, hit uniqueness and the sweep
// bound into the cache top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        mem_req_i,
  input icache_pkg::mem_req_t        mem_req_data_i,
  input logic                        mem_ack_i,
  input logic                        fetch_valid_i,
  input logic                        sweep_i,
  input logic                        cmp_en_i,
  input icache_pkg::icache_addr_u    req_addr_i,
  input icache_pkg::tag_rows_t       tag_rows_i,
  input logic [`ICACHE_NUM_WAYS-1:0] valid_i
);

  logic [`ICACHE_NUM_WAYS-1:0] match_vec;

  // valid tag matches seen in the compare cycle
  always_comb begin
    for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
      match_vec[w] = cmp_en_i & valid_i[w] & (tag_rows_i[w] == req_addr_i.fields.tag);
    end
  end

  // a pending refill request keeps its level and contents
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_req_data_i))
    else $error("refill request dropped or changed before acknowledge");

  // a line lives in one way only
  one_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(match_vec))
    else $error("more than one way hits");

  // no fetch response while sets are cleared
  quiet_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(sweep_i && fetch_valid_i))
    else $error("fetch response during flush sweep");

endmodule

bind icache_top icache_assert icache_assert_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .mem_req_i      (mem_req_o),
  .mem_req_data_i (mem_req_data_o),
  .mem_ack_i      (mem_ack_i),
  .fetch_valid_i  (fetch_valid_o),
  .sweep_i        (sweep),
  .cmp_en_i       (cmp_en),
  .req_addr_i     (req_addr),
  .tag_rows_i     (tag_rows),
  .valid_i        (valid)
);

//--- verif/icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache testbench
// clock, reset, memory model, directed and random fetches, checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_FETCHES = 200;
  // directed tests issue 13 fetches
  localparam int NUM_FETCHES  = 13 + RAND_FETCHES;
  localparam int WAIT_LIMIT   = 200;
  localparam int WORDS        = `ICACHE_LINE_BYTES / 4;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              flush_i;
  logic                              fetch_req_i;
  icache_pkg::icache_addr_u          fetch_addr_i;
  logic                              fetch_ready_o;
  logic                              fetch_valid_o;
  icache_pkg::fetch_rsp_t            fetch_rsp_o;
  logic                              mem_req_o;
  icache_pkg::mem_req_t              mem_req_data_o;
  logic                              mem_ack_i;
  logic                              mem_rtrn_vld_i;
  logic [icache_pkg::LINE_WIDTH-1:0] mem_rtrn_line_i;
  logic                              miss_o;

  // bookkeeping shared by the processes
  integer seed = 32'h5f0df8ec;
  string test_name = "reset";
  int tests_run = 0;
  int test_err = 0;
  int err_cnt = 0;
  int fetch_cnt = 0;
  int resp_cnt = 0;
  int req_cnt = 0;
  int miss_cnt = 0;
  int cyc = 0;
  int last_resp_cyc = 0;
  logic outstanding = 1'b0;
  icache_pkg::mem_req_t last_req;
  // accepted fetch addresses waiting for their word
  logic [31:0] pend_q[$];
  // addresses still to be streamed
  logic [31:0] stim_q[$];

  icache_top icache_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_rsp_o     (fetch_rsp_o),
    .mem_req_o       (mem_req_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_line_i (mem_rtrn_line_i),
    .miss_o          (miss_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // each word is its word address with a marker xored on top
  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    return {2'b00, byte_addr[31:2]} ^ 32'hc0de0000;
  endfunction

  function automatic logic [icache_pkg::LINE_WIDTH-1:0] mem_line(input logic [31:0] line_addr);
    logic [icache_pkg::LINE_WIDTH-1:0] line;
    line = '0;
    for (int w = 0; w < WORDS; w++) begin
      line[w*32 +: 32] = mem_word(line_addr + 32'(w * 4));
    end
    return line;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("ERROR %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock and monitors
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // words come back in order, so the oldest accepted address is due
  always @(posedge clk_i) begin
    logic [31:0] exp_addr;
    if (fetch_valid_o) begin
      resp_cnt++;
      last_resp_cyc = cyc;
      if (pend_q.size() == 0) begin
        report_error("fetch_valid_o without an accepted fetch");
      end else begin
        exp_addr = pend_q.pop_front();
        if (fetch_rsp_o.addr !== exp_addr) begin
          report_mismatch("response address", exp_addr, fetch_rsp_o.addr);
        end
        if (fetch_rsp_o.data !== mem_word(exp_addr)) begin
          report_mismatch("fetch word", mem_word(exp_addr), fetch_rsp_o.data);
        end
      end
    end
    if (fetch_req_i && fetch_ready_o) begin
      pend_q.push_back(fetch_addr_i.raw);
    end
  end

  // refill side, one request in flight at most
  always @(posedge clk_i) begin
    if (mem_req_o && outstanding) begin
      report_error("second refill request before the line returned");
    end
    if (mem_rtrn_vld_i) begin
      outstanding = 1'b0;
    end
    if (mem_req_o && mem_ack_i) begin
      req_cnt++;
      last_req = mem_req_data_o;
      outstanding = 1'b1;
      if ($isunknown(mem_req_data_o.way)) begin
        report_error("refill request carries an unknown victim way");
      end
    end
    if (miss_o) begin
      miss_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int dly;
    logic [31:0] line_addr;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_line_i = '0;
    forever begin
      @(posedge clk_i);
      if (mem_req_o) begin
        line_addr = mem_req_data_o.addr;
        // acknowledge after 0 to 5 cycles
        dly = $unsigned($random(seed)) % 6;
        repeat (dly) @(posedge clk_i);
        #1 mem_ack_i = 1'b1;
        @(posedge clk_i);
        #1 mem_ack_i = 1'b0;
        // line returns 1 to 6 cycles later, in one beat
        dly = 1 + $unsigned($random(seed)) % 6;
        repeat (dly) @(posedge clk_i);
        #1;
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_line_i = mem_line(line_addr);
        @(posedge clk_i);
        #1 mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fetch tasks, entered and left 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  // one fetch, lat is the number of cycles from acceptance to the word
  task automatic fetch_single(input logic [31:0] addr, output int lat);
    int acc_cyc;
    int n;
    fetch_req_i = 1'b1;
    fetch_addr_i.raw = addr;
    fetch_cnt++;
    n = 0;
    @(negedge clk_i);
    while (!fetch_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    acc_cyc = cyc;
    @(posedge clk_i);
    #1 fetch_req_i = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!fetch_valid_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    lat = cyc - acc_cyc;
    if (n >= WAIT_LIMIT) begin
      report_error($sformatf("no fetch_valid_o for address %h", addr));
      lat = -1;
    end
    @(posedge clk_i);
    #1;
  endtask

  // request held high, next address handed over after each acceptance
  task automatic fetch_stream(output int first_acc);
    int n;
    first_acc = -1;
    while (stim_q.size() > 0) begin
      fetch_req_i = 1'b1;
      fetch_addr_i.raw = stim_q[0];
      n = 0;
      @(negedge clk_i);
      while (!fetch_ready_o && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        n++;
      end
      if (n >= WAIT_LIMIT) begin
        report_error("fetch never accepted");
        stim_q.delete();
      end else begin
        if (first_acc < 0) begin
          first_acc = cyc;
        end
        void'(stim_q.pop_front());
        fetch_cnt++;
      end
      @(posedge clk_i);
      #1;
    end
    fetch_req_i = 1'b0;
    // drain the words still in flight
    n = 0;
    while (pend_q.size() > 0 && n < WAIT_LIMIT * 4) begin
      @(negedge clk_i);
      n++;
    end
    if (pend_q.size() > 0) begin
      report_error("accepted fetches never answered");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err  = err_cnt;
    tests_run++;
  endtask

  task automatic finish_test();
    $display("[%0d] %s: %s, %0d errors", tests_run, test_name,
             (err_cnt == test_err) ? "ok" : "with errors", err_cnt - test_err);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed and random tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int wait_cnt;
    int lat;
    int first_acc;
    int req_before;
    int miss_before;
    int resp_before;
    int rnd_line;
    int rnd_word;
    logic [31:0] addr;
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    fetch_req_i      = 1'b0;
    fetch_addr_i.raw = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // sweep after reset, then a cold miss
    start_test("reset_first_miss");
    wait_cnt = 0;
    while (fetch_ready_o !== 1'b1 && wait_cnt < 40) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (wait_cnt > 20) begin
      report_error($sformatf("fetch_ready_o rose only after %0d cycles", wait_cnt));
    end
    @(posedge clk_i);
    #1;
    req_before  = req_cnt;
    miss_before = miss_cnt;
    fetch_single(32'h0000_1238, lat);
    if (req_cnt != req_before + 1) begin
      report_mismatch("refill count", req_before + 1, req_cnt);
    end
    if (last_req.addr !== 32'h0000_1230) begin
      report_mismatch("refill address", 32'h0000_1230, last_req.addr);
    end
    if (miss_cnt != miss_before + 1) begin
      report_mismatch("miss pulses", miss_before + 1, miss_cnt);
    end
    finish_test();

    // same line hits, single and streamed
    start_test("hit_and_stream");
    req_before = req_cnt;
    fetch_single(32'h0000_1230, lat);
    if (lat != 1) begin
      report_mismatch("hit latency", 1, lat);
    end
    stim_q      = {32'h0000_1230, 32'h0000_1234, 32'h0000_1238, 32'h0000_123c};
    resp_before = resp_cnt;
    fetch_stream(first_acc);
    if (resp_cnt != resp_before + 4) begin
      report_mismatch("stream words", resp_before + 4, resp_cnt);
    end
    if (last_resp_cyc - first_acc != 4) begin
      report_mismatch("stream cycles", 4, last_resp_cyc - first_acc);
    end
    if (req_cnt != req_before) begin
      report_mismatch("refill count", req_before, req_cnt);
    end
    finish_test();

    // five lines in set 0 force a replacement
    start_test("same_set");
    req_before = req_cnt;
    for (int i = 0; i < 5; i++) begin
      addr = 32'h0000_4000 + 32'(i) * 32'h100 + 32'((i % WORDS) * 4);
      fetch_single(addr, lat);
      // set 0 starts empty, so the first fills take the free ways in order
      if (i < `ICACHE_NUM_WAYS && 32'(last_req.way) !== 32'(i)) begin
        report_mismatch("victim way", 32'(i), 32'(last_req.way));
      end
    end
    if (req_cnt != req_before + 5) begin
      report_mismatch("refill count", req_before + 5, req_cnt);
    end
    finish_test();

    // flush drops a line that hit before
    start_test("flush");
    req_before = req_cnt;
    fetch_single(32'h0000_1234, lat);
    if (req_cnt != req_before) begin
      report_mismatch("refill count before flush", req_before, req_cnt);
    end
    flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
    fetch_single(32'h0000_1234, lat);
    if (req_cnt != req_before + 1) begin
      report_mismatch("refill count after flush", req_before + 1, req_cnt);
    end
    finish_test();

    // random stream over 64 lines
    start_test("random_stream");
    for (int i = 0; i < RAND_FETCHES; i++) begin
      rnd_line = $unsigned($random(seed)) % 64;
      rnd_word = $unsigned($random(seed)) % WORDS;
      stim_q.push_back(32'h0010_0000 + 32'(rnd_line * 16 + rnd_word * 4));
    end
    resp_before = resp_cnt;
    fetch_stream(first_acc);
    if (resp_cnt != resp_before + RAND_FETCHES) begin
      report_mismatch("random words", resp_before + RAND_FETCHES, resp_cnt);
    end
    finish_test();

    $display("tests %0d, fetches %0d, words %0d, refills %0d, errors %0d",
             tests_run, fetch_cnt, resp_cnt, req_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog, generous per fetch budget plus reset and sweeps
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 40 + WAIT_LIMIT * NUM_FETCHES));
    $display("ERROR watchdog expired during %s at cycle %0d", test_name, cyc);
    $display("test failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_tag_store.sv
rtl/icache_line_store.sv
rtl/icache_way_select.sv
rtl/icache_top.sv
verif/icache_assert.sv
verif/icache_tb.sv

//--- Makefile
# Verilator lint and simulation of the instruction cache testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS    := $(shell grep -v '^+' $(FILELIST)) rtl/icache_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run counts as passed only if the log holds the pass line
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
